// ==== verilog/axi_rd_mon_config.svh ====
/* AXI read monitor configuration
   Bus widths, queue depth and monitor error codes */
`ifndef AXI_RD_MON_CONFIG_SVH
`define AXI_RD_MON_CONFIG_SVH

`define AXI_ID_W        4
`define AXI_ADDR_W      32
`define AXI_DATA_W      32

`define MON_PKT_W       64
`define MON_FIFO_DEPTH  4

`define CG_IDLE_W       4

// Error codes carried in the error view
`define ERR_RESP        4'd1
`define ERR_ORPHAN      4'd2
`define ERR_TIMEOUT     4'd3

`endif

// ==== verilog/axi_rd_mon_pkg.sv ====
/* AXI read monitor types
   Packet type codes and the two decodings of a monitor bus word */
`include "axi_rd_mon_config.svh"

package axi_rd_mon_pkg;

    typedef enum logic [3:0] {
        PKT_COMPL   = 4'h0,
        PKT_ERROR   = 4'h1,
        PKT_TIMEOUT = 4'h2
    } mon_pkt_type_e;

    // Completion view
    typedef struct packed {
        mon_pkt_type_e          pkt_type;
        logic [`AXI_ID_W-1:0]   id;
        logic [15:0]            latency;
        logic [7:0]             beats;
        logic [`AXI_ADDR_W-1:0] addr;
    } mon_compl_t;

    // Error and timeout view
    typedef struct packed {
        mon_pkt_type_e          pkt_type;
        logic [`AXI_ID_W-1:0]   id;
        logic [3:0]             err_code;
        logic [1:0]             resp;
        logic [17:0]            rsvd;
        logic [`AXI_ADDR_W-1:0] addr;
    } mon_error_t;

    typedef union packed {
        mon_compl_t compl;
        mon_error_t err;
    } mon_packet_u;

endpackage

// ==== verilog/axi_clock_gate_ctrl.sv ====
/* Monitor clock gate
   Stops the gated clock after a programmable run of idle cycles */
`timescale 1ns/1ps
`include "axi_rd_mon_config.svh"

module axi_clock_gate_ctrl (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    cfg_cg_enable,
    input  logic [`CG_IDLE_W-1:0]   cfg_cg_idle_count,
    input  logic                    activity,
    output logic                    gclk,
    output logic                    cg_gating,
    output logic                    cg_idle
);

    logic [`CG_IDLE_W-1:0] idle_cnt;
    logic                  clk_en;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (activity) begin
            idle_cnt <= '0;
        end else if (idle_cnt != cfg_cg_idle_count) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // A zero limit never counts as idle
    assign cg_idle   = idle_cnt == cfg_cg_idle_count && idle_cnt != '0;
    assign cg_gating = cg_idle && cfg_cg_enable;

    // Enable only changes while the clock is low
    always_latch begin
        if (!aclk) begin
            clk_en = !cg_gating;
        end
    end

    assign gclk = aclk && clk_en;

endmodule

// ==== verilog/axi_rd_txn_tracker.sv ====
/* Read transaction tracker
   Per-ID outstanding table, completion and error packets, queue and counters */
`timescale 1ns/1ps
`include "axi_rd_mon_config.svh"

module axi_rd_txn_tracker
    import axi_rd_mon_pkg::*;
(
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            ar_fire,
    input  logic [`AXI_ID_W-1:0]            ar_id,
    input  logic [`AXI_ADDR_W-1:0]          ar_addr,
    input  logic [7:0]                      ar_len,
    input  logic                            r_fire,
    input  logic [`AXI_ID_W-1:0]            r_id,
    input  logic [1:0]                      r_resp,
    input  logic                            r_last,
    input  logic                            trk_grant,
    input  logic                            cfg_monitor_enable,
    output logic                            trk_pkt_valid,
    output mon_packet_u                     trk_pkt,
    output logic [(1 << `AXI_ID_W)-1:0]     txn_active,
    output logic [(1 << `AXI_ID_W)-1:0]     txn_start,
    output logic [7:0]                      active_transactions,
    output logic [31:0]                     transaction_count,
    output logic [15:0]                     error_count,
    output logic [7:0]                      drop_count
);

    localparam int NID = 1 << `AXI_ID_W;
    localparam int PW  = $clog2(`MON_FIFO_DEPTH);
    localparam int CW  = PW + 1;

    logic [`AXI_ADDR_W-1:0] tbl_addr  [NID];
    logic [7:0]             tbl_len   [NID];
    logic [7:0]             tbl_beats [NID];
    logic [15:0]            tbl_start [NID];
    logic [15:0]            cycle_cnt;

    mon_packet_u            fifo_mem [`MON_FIFO_DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [CW-1:0]          fifo_cnt;
    logic [CW-1:0]          fifo_free;

    logic                   hit;
    logic                   r_done;
    logic                   err_push;
    logic                   cmp_push;
    logic                   err_ok;
    logic                   cmp_ok;
    mon_packet_u            err_pkt;
    mon_packet_u            cmp_pkt;

    assign hit      = txn_active[r_id];
    assign r_done   = r_fire && hit && r_last;
    assign err_push = cfg_monitor_enable && r_fire && (!hit || r_resp != 2'b00);
    assign cmp_push = cfg_monitor_enable && r_done;

    // Error goes first when a bad last beat needs two slots
    assign fifo_free = CW'(`MON_FIFO_DEPTH) - fifo_cnt;
    assign err_ok    = err_push && fifo_free != '0;
    assign cmp_ok    = cmp_push && fifo_free > CW'(err_ok);

    assign txn_start     = {{(NID-1){1'b0}}, ar_fire} << ar_id;
    assign trk_pkt_valid = fifo_cnt != '0;
    assign trk_pkt       = fifo_mem[rd_ptr];

    always_comb begin
        err_pkt = '0;
        err_pkt.err.pkt_type = PKT_ERROR;
        err_pkt.err.id       = r_id;
        err_pkt.err.err_code = hit ? `ERR_RESP : `ERR_ORPHAN;
        err_pkt.err.resp     = r_resp;
        err_pkt.err.addr     = hit ? tbl_addr[r_id] : '0;

        cmp_pkt.compl.pkt_type = PKT_COMPL;
        cmp_pkt.compl.id       = r_id;
        cmp_pkt.compl.latency  = cycle_cnt - tbl_start[r_id];
        cmp_pkt.compl.beats    = tbl_beats[r_id] + 8'd1;
        cmp_pkt.compl.addr     = tbl_addr[r_id];
    end

    always_ff @(posedge aclk) begin
        if (r_fire && hit) begin
            tbl_beats[r_id] <= tbl_beats[r_id] + 8'd1;
        end
        if (ar_fire) begin
            tbl_addr[ar_id]  <= ar_addr;
            tbl_len[ar_id]   <= ar_len;
            tbl_beats[ar_id] <= '0;
            tbl_start[ar_id] <= cycle_cnt;
        end
        if (err_ok) begin
            fifo_mem[wr_ptr] <= err_pkt;
        end
        if (cmp_ok) begin
            fifo_mem[wr_ptr + PW'(err_ok)] <= cmp_pkt;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            txn_active          <= '0;
            cycle_cnt           <= '0;
            wr_ptr              <= '0;
            rd_ptr              <= '0;
            fifo_cnt            <= '0;
            active_transactions <= '0;
            transaction_count   <= '0;
            error_count         <= '0;
            drop_count          <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 16'd1;
            if (r_done) begin
                txn_active[r_id] <= 1'b0;
            end
            if (ar_fire) begin
                txn_active[ar_id] <= 1'b1;
            end
            wr_ptr   <= wr_ptr + PW'(err_ok) + PW'(cmp_ok);
            rd_ptr   <= rd_ptr + PW'(trk_grant);
            fifo_cnt <= fifo_cnt + CW'(err_ok) + CW'(cmp_ok) - CW'(trk_grant);
            active_transactions <= active_transactions + 8'(ar_fire) - 8'(r_done);
            if (r_done) begin
                transaction_count <= transaction_count + 32'd1;
            end
            if (err_push) begin
                error_count <= error_count + 16'd1;
            end
            drop_count <= drop_count + 8'(err_push && !err_ok) + 8'(cmp_push && !cmp_ok);
        end
    end

    // One read per ID at a time
    assert property (@(posedge aclk) disable iff (!rst_n) ar_fire |-> !txn_active[ar_id]);

    // Arbiter only takes what the queue holds
    assert property (@(posedge aclk) disable iff (!rst_n) trk_grant |-> fifo_cnt != '0);

    // Last beat lands on the burst length of its AR
    assert property (@(posedge aclk) disable iff (!rst_n)
        r_done |-> tbl_beats[r_id] == tbl_len[r_id]);

endmodule

// ==== verilog/axi_rd_timeout_watch.sv ====
/* Read timeout watchdog
   Ages each outstanding ID and reports the first overrun once per read */
`timescale 1ns/1ps
`include "axi_rd_mon_config.svh"

module axi_rd_timeout_watch
    import axi_rd_mon_pkg::*;
(
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic [(1 << `AXI_ID_W)-1:0]     txn_active,
    input  logic [(1 << `AXI_ID_W)-1:0]     txn_start,
    input  logic                            wd_grant,
    input  logic                            cfg_timeout_enable,
    input  logic [15:0]                     cfg_timeout_cycles,
    output logic                            wd_pkt_valid,
    output mon_packet_u                     wd_pkt
);

    localparam int NID = 1 << `AXI_ID_W;

    logic [15:0]           age [NID];
    logic [NID-1:0]        reported;
    logic [NID-1:0]        expired;
    logic                  found;
    logic [`AXI_ID_W-1:0]  found_id;
    logic                  capture;
    mon_packet_u           timeout_pkt;

    always_comb begin
        for (int i = 0; i < NID; i++) begin
            expired[i] = cfg_timeout_enable && txn_active[i] && !reported[i] &&
                         age[i] >= cfg_timeout_cycles;
        end
    end

    // Lowest expired ID wins
    always_comb begin
        found    = 1'b0;
        found_id = '0;
        for (int i = NID - 1; i >= 0; i--) begin
            if (expired[i]) begin
                found    = 1'b1;
                found_id = `AXI_ID_W'(i);
            end
        end
    end

    assign capture = found && !wd_pkt_valid;

    always_comb begin
        timeout_pkt = '0;
        timeout_pkt.err.pkt_type = PKT_TIMEOUT;
        timeout_pkt.err.id       = found_id;
        timeout_pkt.err.err_code = `ERR_TIMEOUT;
        timeout_pkt.err.resp     = 2'b00;
    end

    always_ff @(posedge aclk) begin
        if (capture) begin
            wd_pkt <= timeout_pkt;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            reported     <= '0;
            wd_pkt_valid <= 1'b0;
            for (int i = 0; i < NID; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NID; i++) begin
                if (txn_start[i]) begin
                    age[i] <= '0;
                end else if (txn_active[i] && age[i] != 16'hffff) begin
                    age[i] <= age[i] + 16'd1;
                end
            end
            reported <= reported & ~txn_start;
            if (wd_grant) begin
                wd_pkt_valid <= 1'b0;
            end else if (capture) begin
                wd_pkt_valid       <= 1'b1;
                reported[found_id] <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/monbus_arbiter.sv ====
/* Monitor bus arbiter
   Two-way round robin between the tracker and the watchdog */
`timescale 1ns/1ps
`include "axi_rd_mon_config.svh"

module monbus_arbiter
    import axi_rd_mon_pkg::*;
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    trk_pkt_valid,
    input  mon_packet_u             trk_pkt,
    input  logic                    wd_pkt_valid,
    input  mon_packet_u             wd_pkt,
    input  logic                    monbus_ready,
    output logic                    trk_grant,
    output logic                    wd_grant,
    output logic                    monbus_valid,
    output logic [`MON_PKT_W-1:0]   monbus_packet
);

    logic last_wd;
    logic lock;
    logic lock_wd;
    logic pick_wd;
    logic xfer;

    // A stalled choice stays put until it moves
    always_comb begin
        if (lock) begin
            pick_wd = lock_wd;
        end else if (trk_pkt_valid && wd_pkt_valid) begin
            pick_wd = !last_wd;
        end else begin
            pick_wd = wd_pkt_valid;
        end
    end

    assign monbus_valid  = trk_pkt_valid || wd_pkt_valid;
    assign monbus_packet = pick_wd ? wd_pkt : trk_pkt;
    assign xfer          = monbus_valid && monbus_ready;
    assign wd_grant      = xfer && pick_wd;
    assign trk_grant     = xfer && !pick_wd;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            last_wd <= 1'b0;
            lock    <= 1'b0;
            lock_wd <= 1'b0;
        end else begin
            lock    <= monbus_valid && !monbus_ready;
            lock_wd <= pick_wd;
            if (xfer) begin
                last_wd <= pick_wd;
            end
        end
    end

    // Grants are exclusive and only go to a source that is offering
    assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0({trk_grant, wd_grant}) && (!trk_grant || trk_pkt_valid) &&
        (!wd_grant || wd_pkt_valid));

    // Stalled packet is held on the bus
    assert property (@(posedge aclk) disable iff (!rst_n)
        monbus_valid && !monbus_ready |=> monbus_valid && $stable(monbus_packet));

endmodule

// ==== verilog/axi_rd_mon_cg.sv ====
/* Monitored AXI read slave port with clock gating
   Passes AR and R through and reports reads on the monitor bus */
`timescale 1ns/1ps
`include "axi_rd_mon_config.svh"

module axi_rd_mon_cg
    import axi_rd_mon_pkg::*;
(
    input  logic                        aclk,
    input  logic                        rst_n,

    input  logic [`AXI_ID_W-1:0]        s_axi_arid,
    input  logic [`AXI_ADDR_W-1:0]      s_axi_araddr,
    input  logic [7:0]                  s_axi_arlen,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [`AXI_ID_W-1:0]        s_axi_rid,
    output logic [`AXI_DATA_W-1:0]      s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rlast,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready,

    output logic [`AXI_ID_W-1:0]        fub_axi_arid,
    output logic [`AXI_ADDR_W-1:0]      fub_axi_araddr,
    output logic [7:0]                  fub_axi_arlen,
    output logic                        fub_axi_arvalid,
    input  logic                        fub_axi_arready,
    input  logic [`AXI_ID_W-1:0]        fub_axi_rid,
    input  logic [`AXI_DATA_W-1:0]      fub_axi_rdata,
    input  logic [1:0]                  fub_axi_rresp,
    input  logic                        fub_axi_rlast,
    input  logic                        fub_axi_rvalid,
    output logic                        fub_axi_rready,

    input  logic                        cfg_cg_enable,
    input  logic [`CG_IDLE_W-1:0]       cfg_cg_idle_count,
    input  logic                        cfg_monitor_enable,
    input  logic                        cfg_timeout_enable,
    input  logic [15:0]                 cfg_timeout_cycles,

    output logic                        monbus_valid,
    input  logic                        monbus_ready,
    output logic [`MON_PKT_W-1:0]       monbus_packet,

    output logic                        busy,
    output logic [7:0]                  active_transactions,
    output logic [31:0]                 transaction_count,
    output logic [15:0]                 error_count,
    output logic [7:0]                  drop_count,
    output logic                        cg_gating,
    output logic                        cg_idle
);

    localparam int NID = 1 << `AXI_ID_W;

    logic            gclk;
    logic            activity;
    logic            ar_fire;
    logic            r_fire;
    logic [NID-1:0]  txn_active;
    logic [NID-1:0]  txn_start;
    logic            trk_pkt_valid;
    logic            trk_grant;
    logic            wd_pkt_valid;
    logic            wd_grant;
    mon_packet_u     trk_pkt;
    mon_packet_u     wd_pkt;

    // Readies held low while the monitor clock is stopped
    assign fub_axi_arid    = s_axi_arid;
    assign fub_axi_araddr  = s_axi_araddr;
    assign fub_axi_arlen   = s_axi_arlen;
    assign fub_axi_arvalid = s_axi_arvalid;
    assign s_axi_arready   = fub_axi_arready && !cg_gating;

    assign s_axi_rid       = fub_axi_rid;
    assign s_axi_rdata     = fub_axi_rdata;
    assign s_axi_rresp     = fub_axi_rresp;
    assign s_axi_rlast     = fub_axi_rlast;
    assign s_axi_rvalid    = fub_axi_rvalid;
    assign fub_axi_rready  = s_axi_rready && !cg_gating;

    assign ar_fire  = s_axi_arvalid && s_axi_arready;
    assign r_fire   = fub_axi_rvalid && fub_axi_rready;
    assign busy     = |txn_active;
    assign activity = s_axi_arvalid || fub_axi_rvalid || busy || monbus_valid;

    axi_clock_gate_ctrl u_cg (
        .aclk(aclk), .rst_n(rst_n),
        .cfg_cg_enable(cfg_cg_enable), .cfg_cg_idle_count(cfg_cg_idle_count),
        .activity(activity),
        .gclk(gclk), .cg_gating(cg_gating), .cg_idle(cg_idle)
    );

    axi_rd_txn_tracker u_tracker (
        .aclk(gclk), .rst_n(rst_n),
        .ar_fire(ar_fire), .ar_id(s_axi_arid), .ar_addr(s_axi_araddr), .ar_len(s_axi_arlen),
        .r_fire(r_fire), .r_id(fub_axi_rid), .r_resp(fub_axi_rresp), .r_last(fub_axi_rlast),
        .trk_grant(trk_grant), .cfg_monitor_enable(cfg_monitor_enable),
        .trk_pkt_valid(trk_pkt_valid), .trk_pkt(trk_pkt),
        .txn_active(txn_active), .txn_start(txn_start),
        .active_transactions(active_transactions), .transaction_count(transaction_count),
        .error_count(error_count), .drop_count(drop_count)
    );

    axi_rd_timeout_watch u_watch (
        .aclk(gclk), .rst_n(rst_n),
        .txn_active(txn_active), .txn_start(txn_start), .wd_grant(wd_grant),
        .cfg_timeout_enable(cfg_timeout_enable), .cfg_timeout_cycles(cfg_timeout_cycles),
        .wd_pkt_valid(wd_pkt_valid), .wd_pkt(wd_pkt)
    );

    monbus_arbiter u_arb (
        .aclk(gclk), .rst_n(rst_n),
        .trk_pkt_valid(trk_pkt_valid), .trk_pkt(trk_pkt),
        .wd_pkt_valid(wd_pkt_valid), .wd_pkt(wd_pkt),
        .monbus_ready(monbus_ready),
        .trk_grant(trk_grant), .wd_grant(wd_grant),
        .monbus_valid(monbus_valid), .monbus_packet(monbus_packet)
    );

endmodule

// ==== bench/axi_rd_mon_cg_tb.sv ====
/* Testbench for the monitored AXI read port
   Plays a table of reads through a memory model and checks the monitor packets */
`timescale 1ns/1ps
`include "axi_rd_mon_config.svh"

module axi_rd_mon_cg_tb
    import axi_rd_mon_pkg::*;
;

    localparam int NROWS = 9;

    typedef struct packed {
        logic                   orphan;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [1:0]             resp;
        logic [7:0]             delay;
        logic                   stall;
        logic [7:0]             gap;
        logic                   exp_tmo;
    } row_t;

    logic aclk;
    logic rst_n;
    logic [`AXI_ID_W-1:0] s_axi_arid, s_axi_rid, fub_axi_arid, fub_axi_rid;
    logic [`AXI_ADDR_W-1:0] s_axi_araddr, fub_axi_araddr;
    logic [7:0] s_axi_arlen, fub_axi_arlen;
    logic s_axi_arvalid, s_axi_arready, fub_axi_arvalid, fub_axi_arready;
    logic [`AXI_DATA_W-1:0] s_axi_rdata, fub_axi_rdata;
    logic [1:0] s_axi_rresp, fub_axi_rresp;
    logic s_axi_rlast, s_axi_rvalid, s_axi_rready;
    logic fub_axi_rlast, fub_axi_rvalid, fub_axi_rready;
    logic cfg_cg_enable, cfg_monitor_enable, cfg_timeout_enable;
    logic [`CG_IDLE_W-1:0] cfg_cg_idle_count;
    logic [15:0] cfg_timeout_cycles;
    logic monbus_valid, monbus_ready;
    logic [`MON_PKT_W-1:0] monbus_packet;
    logic busy, cg_gating, cg_idle;
    logic [7:0] active_transactions, drop_count;
    logic [31:0] transaction_count;
    logic [15:0] error_count;

    row_t                   rows [NROWS];
    row_t                   r;
    logic [`MON_PKT_W-1:0]  got_q [$];
    mon_pkt_type_e          exp_type [$];
    logic [`AXI_ID_W-1:0]   exp_id [$];
    logic [`AXI_ADDR_W-1:0] exp_addr [$];
    logic [7:0]             exp_aux [$];
    integer                 seed = 32'h9923;
    integer                 rnd;
    logic                   stall_on;
    int                     cycles;
    int                     limit;
    int                     n_err;
    int                     n_reads;
    int                     row;

    axi_rd_mon_cg uut (.*);

    always #4 aclk = ~aclk;

    always @(negedge aclk) begin
        rnd = $random(seed);
        monbus_ready = stall_on ? rnd[0] : 1'b1;
    end

    // Packets taken at the handshake edge
    always @(posedge aclk) begin
        if (rst_n && monbus_valid && monbus_ready) begin
            got_q.push_back(monbus_packet);
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic int run_limit();
        int i;
        int max_delay;
        int max_beats;
        int gaps;
        max_delay = 0;
        max_beats = 0;
        gaps = 0;
        for (i = 0; i < NROWS; i++) begin
            if (rows[i].delay > max_delay) max_delay = rows[i].delay;
            if (rows[i].len + 1 > max_beats) max_beats = rows[i].len + 1;
            gaps += rows[i].gap;
        end
        return NROWS * (max_delay + max_beats + 20) + gaps + 20;
    endfunction

    task automatic expect_pkt(input mon_pkt_type_e t, input logic [`AXI_ID_W-1:0] id,
                              input logic [`AXI_ADDR_W-1:0] addr, input logic [7:0] aux);
        exp_type.push_back(t);
        exp_id.push_back(id);
        exp_addr.push_back(addr);
        exp_aux.push_back(aux);
    endtask

    task automatic send_ar(input row_t a);
        s_axi_arid    = a.id;
        s_axi_araddr  = a.addr;
        s_axi_arlen   = a.len;
        s_axi_arvalid = 1'b1;
        @(posedge aclk);
        while (!(s_axi_arvalid && s_axi_arready)) @(posedge aclk);
        assert (fub_axi_araddr == a.addr) else begin
            $display("Error: fub_axi_araddr %h expected %h", fub_axi_araddr, a.addr);
            abort_run();
        end
        assert (fub_axi_arvalid && fub_axi_arid == a.id && fub_axi_arlen == a.len) else begin
            $display("Error: fub_axi_arvalid/arid/arlen %h/%h/%h expected 1/%h/%h",
                     fub_axi_arvalid, fub_axi_arid, fub_axi_arlen, a.id, a.len);
            abort_run();
        end
        @(negedge aclk);
        s_axi_arvalid = 1'b0;
    endtask

    // Memory model returns the address plus the beat index
    task automatic return_read(input row_t a);
        int beat;
        logic [1:0] exp_resp;
        repeat (a.delay) @(negedge aclk);
        for (beat = 0; beat <= a.len; beat++) begin
            exp_resp       = (beat == a.len) ? a.resp : 2'b00;
            fub_axi_rid    = a.id;
            fub_axi_rdata  = a.addr + beat;
            fub_axi_rresp  = exp_resp;
            fub_axi_rlast  = beat == a.len;
            fub_axi_rvalid = 1'b1;
            @(posedge aclk);
            while (!fub_axi_rready) @(posedge aclk);
            assert (s_axi_rvalid && s_axi_rdata == a.addr + beat) else begin
                $display("Error: s_axi_rdata %h expected %h", s_axi_rdata, a.addr + beat);
                abort_run();
            end
            assert (s_axi_rid == a.id && s_axi_rlast == (beat == a.len) &&
                    s_axi_rresp == exp_resp) else begin
                $display("Error: s_axi_rid/rlast/rresp %h/%h/%h expected %h/%h/%h",
                         s_axi_rid, s_axi_rlast, s_axi_rresp, a.id, beat == a.len, exp_resp);
                abort_run();
            end
            @(negedge aclk);
        end
        fub_axi_rvalid = 1'b0;
        fub_axi_rlast  = 1'b0;
    endtask

    task automatic check_row_packets();
        mon_packet_u   pkt;
        mon_pkt_type_e t;
        logic [7:0]    aux;
        while (got_q.size() < exp_type.size()) @(negedge aclk);
        repeat (3) @(negedge aclk);
        assert (got_q.size() == exp_type.size()) else begin
            $display("Error: monbus packet count %h expected %h", got_q.size(), exp_type.size());
            abort_run();
        end
        while (exp_type.size() > 0) begin
            pkt = got_q.pop_front();
            t   = exp_type.pop_front();
            aux = exp_aux.pop_front();
            assert (pkt.compl.pkt_type == t && pkt.compl.id == exp_id[0]) else begin
                $display("Error: monbus_packet type/id %h/%h expected %h/%h",
                         pkt.compl.pkt_type, pkt.compl.id, t, exp_id[0]);
                abort_run();
            end
            if (t == PKT_COMPL) begin
                assert (pkt.compl.beats == aux && pkt.compl.latency != 16'h0) else begin
                    $display("Error: monbus_packet beats/latency %h/%h expected %h/nonzero",
                             pkt.compl.beats, pkt.compl.latency, aux);
                    abort_run();
                end
            end else begin
                assert ({pkt.err.err_code, 2'b00, pkt.err.resp} == aux) else begin
                    $display("Error: monbus_packet code/resp %h/%h expected %h",
                             pkt.err.err_code, pkt.err.resp, aux);
                    abort_run();
                end
            end
            assert (pkt.compl.addr == exp_addr[0]) else begin
                $display("Error: monbus_packet addr %h expected %h", pkt.compl.addr, exp_addr[0]);
                abort_run();
            end
            void'(exp_id.pop_front());
            void'(exp_addr.pop_front());
        end
    endtask

    initial begin
        // orphan, id, addr, len, resp, delay, stall, gap, exp_tmo
        rows[0] = '{1'b0, 4'h1, 32'h0000_1000, 8'd0, 2'b00, 8'd2,  1'b0, 8'd0,  1'b0};
        rows[1] = '{1'b0, 4'h2, 32'h0000_2000, 8'd3, 2'b00, 8'd1,  1'b0, 8'd0,  1'b0};
        rows[2] = '{1'b0, 4'h3, 32'h0000_3040, 8'd1, 2'b10, 8'd3,  1'b0, 8'd0,  1'b0};
        rows[3] = '{1'b0, 4'h4, 32'h0000_4100, 8'd2, 2'b11, 8'd0,  1'b1, 8'd0,  1'b0};
        rows[4] = '{1'b1, 4'h9, 32'h0000_0000, 8'd0, 2'b00, 8'd0,  1'b0, 8'd0,  1'b0};
        rows[5] = '{1'b0, 4'h5, 32'h0000_5000, 8'd1, 2'b00, 8'd40, 1'b1, 8'd0,  1'b1};
        rows[6] = '{1'b0, 4'h6, 32'h0000_6000, 8'd7, 2'b00, 8'd2,  1'b1, 8'd0,  1'b0};
        rows[7] = '{1'b0, 4'h7, 32'h0000_7000, 8'd2, 2'b10, 8'd1,  1'b1, 8'd0,  1'b0};
        rows[8] = '{1'b0, 4'h8, 32'h0000_8200, 8'd1, 2'b00, 8'd1,  1'b0, 8'd24, 1'b0};
        limit   = run_limit();
        cycles  = 0;
        n_err   = 0;
        n_reads = 0;

        aclk = 1'b0;
        rst_n = 1'b0;
        stall_on = 1'b0;
        monbus_ready = 1'b1;
        s_axi_arid = '0;
        s_axi_araddr = '0;
        s_axi_arlen = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b1;
        fub_axi_arready = 1'b1;
        fub_axi_rid = '0;
        fub_axi_rdata = '0;
        fub_axi_rresp = 2'b00;
        fub_axi_rlast = 1'b0;
        fub_axi_rvalid = 1'b0;
        cfg_cg_enable = 1'b1;
        cfg_cg_idle_count = 4'd8;
        cfg_monitor_enable = 1'b1;
        cfg_timeout_enable = 1'b1;
        cfg_timeout_cycles = 16'd20;

        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        for (row = 0; row < NROWS; row++) begin
            r = rows[row];
            stall_on = r.stall;
            repeat (r.gap) @(negedge aclk);
            // Long idle gap should have stopped the monitor clock
            if (r.gap != 0) begin
                assert (cg_idle && cg_gating && !s_axi_arready) else begin
                    $display("Error: cg_idle/cg_gating/s_axi_arready %h/%h/%h expected 1/1/0",
                             cg_idle, cg_gating, s_axi_arready);
                    abort_run();
                end
            end
            if (r.orphan) begin
                expect_pkt(PKT_ERROR, r.id, '0, {`ERR_ORPHAN, 2'b00, r.resp});
                n_err++;
                return_read(r);
            end else begin
                if (r.exp_tmo) expect_pkt(PKT_TIMEOUT, r.id, '0, {`ERR_TIMEOUT, 4'h0});
                if (r.resp != 2'b00) begin
                    expect_pkt(PKT_ERROR, r.id, r.addr, {`ERR_RESP, 2'b00, r.resp});
                    n_err++;
                end
                expect_pkt(PKT_COMPL, r.id, r.addr, r.len + 8'd1);
                n_reads++;
                send_ar(r);
                return_read(r);
            end
            check_row_packets();
        end

        assert (error_count == 16'(n_err)) else begin
            $display("Error: error_count %h expected %h", error_count, n_err);
            abort_run();
        end
        assert (transaction_count == 32'(n_reads)) else begin
            $display("Error: transaction_count %h expected %h", transaction_count, n_reads);
            abort_run();
        end
        assert (drop_count == 8'h0 && active_transactions == 8'h0 && !busy) else begin
            $display("Error: drop_count/active_transactions/busy %h/%h/%h expected 0/0/0",
                     drop_count, active_transactions, busy);
            abort_run();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== axi_rd_mon.f ====
+incdir+verilog
verilog/axi_rd_mon_pkg.sv
verilog/axi_clock_gate_ctrl.sv
verilog/axi_rd_txn_tracker.sv
verilog/axi_rd_timeout_watch.sv
verilog/monbus_arbiter.sv
verilog/axi_rd_mon_cg.sv
bench/axi_rd_mon_cg_tb.sv
